//--- source/ctrl_bus_pkg.sv
// Wishbone bus widths and the slave address map of the control slice
// Shared by the decoder, the slave interface, the boot window logic and the top level

package ctrl_bus_pkg;

   //////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////

   localparam int ADR_W = 16;
   localparam int DAT_W = 32;

   // Upper address bits taking part in region decode
   localparam int DECODE_W = 8;

   typedef logic [ADR_W-1:0]    wb_adr_t;
   typedef logic [DAT_W-1:0]    wb_dat_t;
   typedef logic [DECODE_W-1:0] dec_t;

   //////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////

   // Readback words, 1 KB window
   localparam wb_adr_t RB_BASE = 16'h5C00;
   localparam wb_adr_t RB_MASK = 16'hFC00;

   // Settings bus, 4 KB window
   localparam wb_adr_t SET_BASE = 16'h7000;
   localparam wb_adr_t SET_MASK = 16'hF000;

endpackage

//--- source/ctrl_regs_pkg.sv
// Setting register map, reset values and readback word layout
// Also holds the bootloader state encoding and the RAM window swap mask

package ctrl_regs_pkg;

   typedef logic [7:0] set_addr_t;
   typedef logic [7:0] led_t;
   typedef logic [3:0] rb_idx_t;

   // Byte address bit where the settings address starts
   localparam int SET_ADR_LSB = 2;
   // Byte address bit where the readback word index starts
   localparam int RB_ADR_LSB = 2;

   //////////////////////////////////////////////////
   // Setting addresses
   //////////////////////////////////////////////////

   localparam set_addr_t SR_MISC      = 8'd0;
   localparam set_addr_t MISC_FE_RST  = 8'd0;
   localparam set_addr_t MISC_LED_SW  = 8'd3;
   localparam set_addr_t MISC_PHY_RST = 8'd4;
   localparam set_addr_t MISC_BLDR    = 8'd5;
   localparam set_addr_t MISC_LED_SRC = 8'd6;

   // Two diversity switches at consecutive addresses
   localparam set_addr_t SR_DIVSW = 8'd180;

   // Reset values
   localparam led_t LED_SRC_RESET = 8'h1E;
   localparam logic DIVSW_RESET   = 1'b1;

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////

   localparam logic [15:0] COMPAT_MAJOR = 16'd9;
   localparam logic [15:0] COMPAT_MINOR = 16'd0;
   localparam ctrl_bus_pkg::wb_dat_t COMPAT_NUM = {COMPAT_MAJOR, COMPAT_MINOR};

   localparam rb_idx_t RB_COMPAT_IDX = 4'd12;
   localparam rb_idx_t RB_STATUS_IDX = 4'd13;

   // Bootloader handover
   typedef enum logic {
      BOOT_WAIT = 1'b0,
      BOOT_DONE = 1'b1
   } boot_state_e;

   localparam ctrl_bus_pkg::wb_adr_t RAM_SWAP_MASK = 16'hC000;

endpackage

//--- source/wb_slave_if.sv
// Single-slave Wishbone link between the address decoder and one slave
// The decoder takes the master modport, the slave block the slave modport

`timescale 1ns/1ps

interface wb_slave_if;

   logic                  stb;
   logic                  we;
   ctrl_bus_pkg::wb_adr_t adr;
   ctrl_bus_pkg::wb_dat_t dat_w;
   ctrl_bus_pkg::wb_dat_t dat_r;
   logic                  ack;

   modport master (output stb, output we, output adr, output dat_w,
                   input dat_r, input ack);

   modport slave (input stb, input we, input adr, input dat_w,
                  output dat_r, output ack);

endinterface

//--- source/wb_slave_decode.sv
// Wishbone address decoder for the settings and readback regions
// Routes stb to the matching slave and returns its data and ack
// Unmapped cycles are acked here with zero data so the bus never hangs

`timescale 1ns/1ps

module wb_slave_decode (
   input  logic                  wb_clk,
   input  logic                  por_rst,
   input  ctrl_bus_pkg::wb_adr_t wb_adr_i,
   input  ctrl_bus_pkg::wb_dat_t wb_dat_i,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   output ctrl_bus_pkg::wb_dat_t wb_dat_o,
   output logic                  wb_ack_o,
   wb_slave_if.master            set_bus,
   wb_slave_if.master            rb_bus
);

   localparam int HI = ctrl_bus_pkg::ADR_W - 1;
   localparam int DW = ctrl_bus_pkg::DECODE_W;

   ctrl_bus_pkg::dec_t adr_dec;
   logic               stb;
   logic               set_hit;
   logic               rb_hit;
   logic               def_ack;

   assign stb     = wb_stb_i & wb_cyc_i;
   assign adr_dec = wb_adr_i[HI -: DW];

   // Region match on the upper address bits
   assign set_hit = (adr_dec & ctrl_bus_pkg::SET_MASK[HI -: DW])
                    == ctrl_bus_pkg::SET_BASE[HI -: DW];
   assign rb_hit  = (adr_dec & ctrl_bus_pkg::RB_MASK[HI -: DW])
                    == ctrl_bus_pkg::RB_BASE[HI -: DW];

   // Request side, shared address and data
   assign set_bus.stb   = stb & set_hit;
   assign set_bus.we    = wb_we_i;
   assign set_bus.adr   = wb_adr_i;
   assign set_bus.dat_w = wb_dat_i;

   assign rb_bus.stb   = stb & rb_hit;
   assign rb_bus.we    = wb_we_i;
   assign rb_bus.adr   = wb_adr_i;
   assign rb_bus.dat_w = wb_dat_i;

   // Default slave for unmapped addresses
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         def_ack <= 1'b0;
      end else begin
         def_ack <= stb & ~set_hit & ~rb_hit & ~def_ack;
      end
   end

   // Return path
   assign wb_dat_o = rb_hit ? rb_bus.dat_r : (set_hit ? set_bus.dat_r : '0);
   assign wb_ack_o = (set_hit & set_bus.ack) | (rb_hit & rb_bus.ack) | def_ack;

   // One ack per request, whichever slave answers
   a_single_ack : assert property (@(posedge wb_clk) disable iff (por_rst)
      (stb && wb_ack_o) |=> !(stb && wb_ack_o))
      else $error("ack held for two cycles with stb high");

endmodule

//--- source/setting_reg_bank.sv
// Settings bus writer, the board-control setting registers and the LED mux
// Registers load on the edge that acks the write, so outputs change with ack
// All registers return to their reset values on por_rst or soft_rst_i

`timescale 1ns/1ps

module setting_reg_bank (
   input  logic                wb_clk,
   input  logic                por_rst,
   input  logic                soft_rst_i,
   input  logic [3:0]          run_i,
   output logic                bldr_done_o,
   output ctrl_regs_pkg::led_t leds_o,
   output logic [1:0]          lms_res_o,
   output logic                phy_resetn_o,
   output logic [1:0]          div_sw_o,
   wb_slave_if.slave           set_bus
);

   logic                     rst;
   logic                     set_stb;
   ctrl_regs_pkg::set_addr_t set_addr;
   ctrl_bus_pkg::wb_dat_t    set_data;
   logic [1:0]               lms_res_q;
   ctrl_regs_pkg::led_t      led_sw_q;
   ctrl_regs_pkg::led_t      led_src_q;
   logic                     phy_rst_q;
   logic                     bldr_done_q;
   logic                     div_sw1_q;
   logic                     div_sw2_q;
   ctrl_regs_pkg::led_t      led_hw;

   assign rst = por_rst | soft_rst_i;

   //////////////////////////////////////////////////
   // Settings bus writer
   //////////////////////////////////////////////////

   // One strobe per write, on the edge that raises ack
   assign set_stb  = set_bus.stb & set_bus.we & ~set_bus.ack;
   assign set_addr = set_bus.adr[ctrl_regs_pkg::SET_ADR_LSB +: $bits(ctrl_regs_pkg::set_addr_t)];
   assign set_data = set_bus.dat_w;

   // Reads are acked too and return zero
   always_ff @(posedge wb_clk) begin
      if (rst) begin
         set_bus.ack <= 1'b0;
      end else begin
         set_bus.ack <= set_bus.stb & ~set_bus.ack;
      end
   end

   assign set_bus.dat_r = '0;

   //////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (rst) begin
         lms_res_q   <= '0;
         led_sw_q    <= '0;
         phy_rst_q   <= 1'b0;
         bldr_done_q <= 1'b0;
         led_src_q   <= ctrl_regs_pkg::LED_SRC_RESET;
         div_sw1_q   <= ctrl_regs_pkg::DIVSW_RESET;
         div_sw2_q   <= ctrl_regs_pkg::DIVSW_RESET;
      end else if (set_stb) begin
         case (set_addr)
            ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_FE_RST:  lms_res_q   <= set_data[1:0];
            ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_LED_SW:  led_sw_q    <= set_data[7:0];
            ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_PHY_RST: phy_rst_q   <= set_data[0];
            ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_BLDR:    bldr_done_q <= set_data[0];
            ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_LED_SRC: led_src_q   <= set_data[7:0];
            ctrl_regs_pkg::SR_DIVSW:                              div_sw1_q   <= set_data[0];
            ctrl_regs_pkg::SR_DIVSW + 8'd1:                       div_sw2_q   <= set_data[0];
            // Unknown addresses are ignored
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Outputs and LED source mux
   //////////////////////////////////////////////////

   // Run indicators in bits 4..1
   assign led_hw = {3'b000, run_i, 1'b0};

   // Source bit 1 selects hardware, 0 selects software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign lms_res_o    = lms_res_q;
   assign phy_resetn_o = ~phy_rst_q;
   assign bldr_done_o  = bldr_done_q;
   assign div_sw_o     = {div_sw2_q, div_sw1_q};

   // Master holds stb until it sees ack
   a_ack_with_stb : assert property (@(posedge wb_clk) disable iff (rst)
      set_bus.ack |-> set_bus.stb)
      else $error("settings ack without stb");

endmodule

//--- source/boot_reset_ctrl.sv
// Bootloader handover: one soft reset pulse once the bootloader reports done
// Until then boot RAM and main RAM swap places in the CPU address map

`timescale 1ns/1ps

module boot_reset_ctrl (
   input  logic                  wb_clk,
   input  logic                  por_rst,
   input  logic                  bldr_done_i,
   input  ctrl_bus_pkg::wb_adr_t cpu_adr_i,
   output logic                  soft_rst_o,
   output ctrl_bus_pkg::wb_adr_t bus_adr_o
);

   ctrl_regs_pkg::boot_state_e state_q;
   logic                       swap;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q    <= ctrl_regs_pkg::BOOT_WAIT;
         soft_rst_o <= 1'b1;
      end else begin
         case (state_q)
            ctrl_regs_pkg::BOOT_WAIT: begin
               soft_rst_o <= 1'b0;
               // Single pulse, settings return to reset values
               if (bldr_done_i) begin
                  state_q    <= ctrl_regs_pkg::BOOT_DONE;
                  soft_rst_o <= 1'b1;
               end
            end
            ctrl_regs_pkg::BOOT_DONE: begin
               soft_rst_o <= 1'b0;
            end
         endcase
      end
   end

   // Top two bits equal means boot RAM or main RAM
   assign swap = (state_q == ctrl_regs_pkg::BOOT_WAIT) && (cpu_adr_i[15] == cpu_adr_i[14]);
   assign bus_adr_o = swap ? (cpu_adr_i ^ ctrl_regs_pkg::RAM_SWAP_MASK) : cpu_adr_i;

   a_done_sticky : assert property (@(posedge wb_clk)
      (state_q == ctrl_regs_pkg::BOOT_DONE) && !por_rst |=> state_q == ctrl_regs_pkg::BOOT_DONE)
      else $error("boot state left BOOT_DONE without power-on reset");

endmodule

//--- source/readback_mux.sv
// Readback region: compatibility number and board status words
// Word and ack are registered together, one cycle after stb

`timescale 1ns/1ps

module readback_mux (
   input  logic       wb_clk,
   input  logic       por_rst,
   input  logic [1:0] lock_det_i,
   input  logic       button_i,
   input  logic       spi_ready_i,
   wb_slave_if.slave  rb_bus
);

   ctrl_regs_pkg::rb_idx_t word_idx;
   ctrl_bus_pkg::wb_dat_t  status;
   ctrl_bus_pkg::wb_dat_t  word;

   assign word_idx = rb_bus.adr[ctrl_regs_pkg::RB_ADR_LSB +: $bits(ctrl_regs_pkg::rb_idx_t)];

   // Status bits in 19..16
   assign status = {12'b0, lock_det_i[1], lock_det_i[0], button_i, spi_ready_i, 16'b0};

   always_comb begin
      case (word_idx)
         ctrl_regs_pkg::RB_COMPAT_IDX: word = ctrl_regs_pkg::COMPAT_NUM;
         ctrl_regs_pkg::RB_STATUS_IDX: word = status;
         default:                      word = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         rb_bus.ack <= 1'b0;
      end else begin
         rb_bus.ack <= rb_bus.stb & ~rb_bus.ack;
      end
   end

   // Captured on the ack edge, held until the next access
   always_ff @(posedge wb_clk) begin
      if (rb_bus.stb && !rb_bus.ack) begin
         rb_bus.dat_r <= word;
      end
   end

endmodule

//--- source/umtrx_ctrl_top.sv
// Board-control slice of the transceiver core, all on wb_clk
// Wishbone slave for settings and readback, LED mux and bootloader reset

`timescale 1ns/1ps

module umtrx_ctrl_top (
   input  logic                  wb_clk,
   input  logic                  por_rst,
   input  ctrl_bus_pkg::wb_adr_t wb_adr_i,
   input  ctrl_bus_pkg::wb_dat_t wb_dat_i,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   input  ctrl_bus_pkg::wb_adr_t cpu_adr_i,
   input  logic [3:0]            run_i,
   input  logic [1:0]            lock_det_i,
   input  logic                  button_i,
   input  logic                  spi_ready_i,
   output ctrl_bus_pkg::wb_dat_t wb_dat_o,
   output logic                  wb_ack_o,
   output ctrl_bus_pkg::wb_adr_t bus_adr_o,
   output logic                  soft_rst_o,
   output ctrl_regs_pkg::led_t   leds_o,
   output logic [1:0]            lms_res_o,
   output logic                  phy_resetn_o,
   output logic [1:0]            div_sw_o
);

   logic bldr_done;

   wb_slave_if set_bus ();
   wb_slave_if rb_bus ();

   //////////////////////////////////////////////////
   // Bus decode
   //////////////////////////////////////////////////

   wb_slave_decode decode_i (
      .wb_clk   (wb_clk),
      .por_rst  (por_rst),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .set_bus  (set_bus.master),
      .rb_bus   (rb_bus.master)
   );

   //////////////////////////////////////////////////
   // Settings, boot control, readback
   //////////////////////////////////////////////////

   setting_reg_bank regs_i (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .soft_rst_i   (soft_rst_o),
      .run_i        (run_i),
      .bldr_done_o  (bldr_done),
      .leds_o       (leds_o),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .div_sw_o     (div_sw_o),
      .set_bus      (set_bus.slave)
   );

   boot_reset_ctrl boot_i (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .cpu_adr_i   (cpu_adr_i),
      .soft_rst_o  (soft_rst_o),
      .bus_adr_o   (bus_adr_o)
   );

   readback_mux rb_i (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .lock_det_i  (lock_det_i),
      .button_i    (button_i),
      .spi_ready_i (spi_ready_i),
      .rb_bus      (rb_bus.slave)
   );

endmodule

//--- tb/ctrl_checker.sv
// Checker for the board-control testbench
// Watches the bus and the DUT outputs, compares them with the expected values
// from the driver and keeps a model of the soft reset pulse

`timescale 1ns/1ps

module ctrl_checker (
   input  logic                  wb_clk,
   input  logic                  por_rst,
   input  logic                  stb_i,
   input  logic                  cyc_i,
   input  logic                  we_i,
   input  ctrl_bus_pkg::wb_adr_t adr_i,
   input  ctrl_bus_pkg::wb_dat_t wdat_i,
   input  ctrl_bus_pkg::wb_dat_t rdat_i,
   input  logic                  ack_i,
   input  ctrl_bus_pkg::wb_adr_t bus_adr_i,
   input  logic                  soft_rst_i,
   input  ctrl_regs_pkg::led_t   leds_i,
   input  logic [1:0]            lms_res_i,
   input  logic                  phy_resetn_i,
   input  logic [1:0]            div_sw_i,
   input  logic                  rd_chk_i,
   input  ctrl_bus_pkg::wb_dat_t rd_exp_i,
   input  logic                  adr_chk_i,
   input  ctrl_bus_pkg::wb_adr_t adr_exp_i,
   input  logic                  out_chk_i,
   input  ctrl_regs_pkg::led_t   leds_exp_i,
   input  logic [1:0]            lms_exp_i,
   input  logic                  phyn_exp_i,
   input  logic [1:0]            divsw_exp_i,
   output int                    err_cnt_o,
   output int                    chk_cnt_o
);

   localparam int ACK_LIMIT = 4;

   int   err_cnt = 0;
   int   chk_cnt = 0;
   int   wait_cnt;
   logic srst_exp;
   logic boot_done;
   logic bus_req;
   logic bldr_wr;

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;
   assign bus_req   = stb_i & cyc_i;

   // Acked write of 1 to the bootloader-done setting
   assign bldr_wr = bus_req & we_i & ack_i & wdat_i[0]
                    & ((adr_i & ctrl_bus_pkg::SET_MASK) == ctrl_bus_pkg::SET_BASE)
                    & (adr_i[9:2] == ctrl_regs_pkg::SR_MISC + ctrl_regs_pkg::MISC_BLDR);

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("ERR %0t: %s is %0h, expected %0h", $realtime, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_fault(input string msg);
      $display("At %0t: %s", $realtime, msg);
      err_cnt++;
   endtask

   //////////////////////////////////////////////////
   // Sampling on the rising edge, inputs settled since the falling edge
   //////////////////////////////////////////////////

   always @(posedge wb_clk) begin
      if (por_rst) begin
         wait_cnt  <= 0;
         srst_exp  <= 1'b1;
         boot_done <= 1'b0;
      end else begin
         // Handshake
         if (bus_req && !ack_i) begin
            wait_cnt <= wait_cnt + 1;
            if (wait_cnt == ACK_LIMIT - 1) begin
               report_fault($sformatf("bus cycle to %h got no ack within %0d cycles",
                                      adr_i, ACK_LIMIT));
            end
         end else begin
            wait_cnt <= 0;
         end
         if (ack_i && !bus_req) begin
            report_fault("ack came while no bus cycle was open");
         end
         if (ack_i && bus_req) begin
            compare_value("ack latency", wait_cnt, 1);
         end

         if (rd_chk_i && bus_req && ack_i && !we_i) begin
            compare_value($sformatf("read data at %h", adr_i), rdat_i, rd_exp_i);
         end
         if (adr_chk_i) begin
            compare_value("bus_adr_o", bus_adr_i, adr_exp_i);
         end
         if (out_chk_i) begin
            compare_value("leds_o", leds_i, leds_exp_i);
            compare_value("lms_res_o", lms_res_i, lms_exp_i);
            compare_value("phy_resetn_o", phy_resetn_i, phyn_exp_i);
            compare_value("div_sw_o", div_sw_i, divsw_exp_i);
         end

         // One soft reset pulse, the cycle after the first bootloader-done ack
         compare_value("soft_rst_o", soft_rst_i, srst_exp);
         srst_exp <= bldr_wr & ~boot_done;
         if (bldr_wr) begin
            boot_done <= 1'b1;
         end
      end
   end

endmodule

//--- tb/tb_umtrx_ctrl.sv
// Testbench for the board-control slice
// Reads one operation per line from tb/ctrl_tests.txt and drives the Wishbone port
// The checker module compares the DUT outputs and counts errors

`timescale 1ns/1ps

module tb_umtrx_ctrl;

   localparam string TEST_FILE    = "tb/ctrl_tests.txt";
   localparam int    ACK_WAIT_MAX = 6;

   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
   } test_op_t;

   logic                  wb_clk;
   logic                  por_rst;
   ctrl_bus_pkg::wb_adr_t wb_adr_i;
   ctrl_bus_pkg::wb_dat_t wb_dat_i;
   logic                  wb_we_i;
   logic                  wb_stb_i;
   logic                  wb_cyc_i;
   ctrl_bus_pkg::wb_adr_t cpu_adr_i;
   logic [3:0]            run_i;
   logic [1:0]            lock_det_i;
   logic                  button_i;
   logic                  spi_ready_i;
   ctrl_bus_pkg::wb_dat_t wb_dat_o;
   logic                  wb_ack_o;
   ctrl_bus_pkg::wb_adr_t bus_adr_o;
   logic                  soft_rst_o;
   ctrl_regs_pkg::led_t   leds_o;
   logic [1:0]            lms_res_o;
   logic                  phy_resetn_o;
   logic [1:0]            div_sw_o;

   // Expected values handed to the checker
   logic                  rd_chk;
   ctrl_bus_pkg::wb_dat_t rd_exp;
   logic                  adr_chk;
   ctrl_bus_pkg::wb_adr_t adr_exp;
   logic                  out_chk;
   ctrl_regs_pkg::led_t   leds_exp;
   logic [1:0]            lms_exp;
   logic                  phyn_exp;
   logic [1:0]            divsw_exp;

   int       err_cnt;
   int       chk_cnt;
   int       load_errs = 0;
   int       cycles = 0;
   int       cycle_limit = 20;
   test_op_t tests[$];

   always #10 wb_clk = ~wb_clk;

   umtrx_ctrl_top dut_i (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_we_i      (wb_we_i),
      .wb_stb_i     (wb_stb_i),
      .wb_cyc_i     (wb_cyc_i),
      .cpu_adr_i    (cpu_adr_i),
      .run_i        (run_i),
      .lock_det_i   (lock_det_i),
      .button_i     (button_i),
      .spi_ready_i  (spi_ready_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .bus_adr_o    (bus_adr_o),
      .soft_rst_o   (soft_rst_o),
      .leds_o       (leds_o),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .div_sw_o     (div_sw_o)
   );

   ctrl_checker check_i (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .stb_i        (wb_stb_i),
      .cyc_i        (wb_cyc_i),
      .we_i         (wb_we_i),
      .adr_i        (wb_adr_i),
      .wdat_i       (wb_dat_i),
      .rdat_i       (wb_dat_o),
      .ack_i        (wb_ack_o),
      .bus_adr_i    (bus_adr_o),
      .soft_rst_i   (soft_rst_o),
      .leds_i       (leds_o),
      .lms_res_i    (lms_res_o),
      .phy_resetn_i (phy_resetn_o),
      .div_sw_i     (div_sw_o),
      .rd_chk_i     (rd_chk),
      .rd_exp_i     (rd_exp),
      .adr_chk_i    (adr_chk),
      .adr_exp_i    (adr_exp),
      .out_chk_i    (out_chk),
      .leds_exp_i   (leds_exp),
      .lms_exp_i    (lms_exp),
      .phyn_exp_i   (phyn_exp),
      .divsw_exp_i  (divsw_exp),
      .err_cnt_o    (err_cnt),
      .chk_cnt_o    (chk_cnt)
   );

   //////////////////////////////////////////////////
   // Test file
   //////////////////////////////////////////////////

   task automatic load_tests();
      int          fd;
      int          n;
      int          ch;
      int          need;
      bit          done;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      test_op_t    t;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open test file %s", TEST_FILE);
         load_errs++;
      end else begin
         done = 1'b0;
         while (!done) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
               done = 1'b1;
            end else if (op == "#") begin
               // Comment runs to end of line
               ch = $fgetc(fd);
               while (ch != "\n" && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else begin
               a = '0;
               b = '0;
               c = '0;
               d = '0;
               if (op == "S" || op == "E") begin
                  need = 4;
                  n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
               end else begin
                  need = 2;
                  n = $fscanf(fd, "%h %h", a, b);
               end
               if (n == need && (op == "W" || op == "R" || op == "A" || op == "S" || op == "E")) begin
                  t = {op, a, b, c, d};
                  tests.push_back(t);
               end else begin
                  $display("Bad line in test file after %0d operations", tests.size());
                  load_errs++;
                  done = 1'b1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   //////////////////////////////////////////////////
   // Operations, each starts and ends on a falling edge
   //////////////////////////////////////////////////

   task automatic bus_cycle(input logic we, input ctrl_bus_pkg::wb_adr_t adr,
                            input ctrl_bus_pkg::wb_dat_t dat);
      int waited;
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_dat_i = we ? dat : '0;
      rd_exp   = we ? '0 : dat;
      rd_chk   = ~we;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      waited   = 0;
      @(negedge wb_clk);
      while (!wb_ack_o && waited < ACK_WAIT_MAX) begin
         @(negedge wb_clk);
         waited++;
      end
      // Keep stb over the edge that drops ack
      @(negedge wb_clk);
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
      rd_chk   = 1'b0;
   endtask

   task automatic set_status(input test_op_t t);
      run_i       = t.a[3:0];
      lock_det_i  = t.b[1:0];
      button_i    = t.c[0];
      spi_ready_i = t.d[0];
      @(negedge wb_clk);
   endtask

   task automatic check_window(input test_op_t t);
      cpu_adr_i = t.a[15:0];
      adr_exp   = t.b[15:0];
      adr_chk   = 1'b1;
      @(negedge wb_clk);
      adr_chk   = 1'b0;
   endtask

   task automatic check_outputs(input test_op_t t);
      leds_exp  = t.a[7:0];
      lms_exp   = t.b[1:0];
      phyn_exp  = t.c[0];
      divsw_exp = t.d[1:0];
      out_chk   = 1'b1;
      @(negedge wb_clk);
      out_chk   = 1'b0;
   endtask

   // Run limit from the number of operations
   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      $timeformat(-9, 0, " ns", 0);
      wb_clk      = 1'b0;
      por_rst     = 1'b1;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      wb_we_i     = 1'b0;
      wb_stb_i    = 1'b0;
      wb_cyc_i    = 1'b0;
      cpu_adr_i   = '0;
      run_i       = '0;
      lock_det_i  = '0;
      button_i    = 1'b0;
      spi_ready_i = 1'b0;
      rd_chk      = 1'b0;
      rd_exp      = '0;
      adr_chk     = 1'b0;
      adr_exp     = '0;
      out_chk     = 1'b0;
      leds_exp    = '0;
      lms_exp     = '0;
      phyn_exp    = 1'b0;
      divsw_exp   = '0;

      load_tests();
      cycle_limit = 8 * tests.size() + 20;

      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      por_rst = 1'b0;
      // Soft reset still high for one cycle after power-on reset
      repeat (2) @(negedge wb_clk);

      foreach (tests[i]) begin
         case (tests[i].op)
            "W": bus_cycle(1'b1, tests[i].a[15:0], tests[i].b);
            "R": bus_cycle(1'b0, tests[i].a[15:0], tests[i].b);
            "A": check_window(tests[i]);
            "S": set_status(tests[i]);
            default: check_outputs(tests[i]);
         endcase
      end
      repeat (2) @(negedge wb_clk);

      $display("Operations: %0d, checks: %0d, errors: %0d", tests.size(), chk_cnt,
               err_cnt + load_errs);
      if (err_cnt == 0 && load_errs == 0 && chk_cnt > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- tb/ctrl_tests.txt
# op a b c d, all hex: W adr data | R adr expected | A cpu_adr expected_bus_adr
# S run lock button spi | E expected_leds expected_lms expected_phyn expected_divsw
S A 0 0 0
E 14 0 1 3
R 5C00 00000000
R 5C30 00090000
W 7000 00000002
W 7010 00000001
W 700C 000000A5
W 72D0 00000000
E B5 2 0 2
W 7008 FFFFFFFF
E B5 2 0 2
W 72D4 00000000
E B5 2 0 0
W 7018 0000000F
S 5 0 0 0
E AA 2 0 0
S F 0 0 0
E AE 2 0 0
W 7018 000000FF
E 1E 2 0 0
W 7018 00000000
E A5 2 0 0
S F 2 1 0
R 5C34 000A0000
S F 1 0 1
R 5C34 00050000
R 1000 00000000
W 2000 12345678
R 5C3C 00000000
A 0010 C010
A 4010 4010
A C010 0010
W 7014 00000001
A 0010 0010
E 1E 0 1 3
R 5C30 00090000

//--- all.f
source/ctrl_bus_pkg.sv
source/ctrl_regs_pkg.sv
source/wb_slave_if.sv
source/wb_slave_decode.sv
source/setting_reg_bank.sv
source/boot_reset_ctrl.sv
source/readback_mux.sv
source/umtrx_ctrl_top.sv
tb/ctrl_checker.sv
tb/tb_umtrx_ctrl.sv

//--- Bender.yml
package:
  name: umtrx_ctrl

sources:
  - files:
      - source/ctrl_bus_pkg.sv
      - source/ctrl_regs_pkg.sv
      - source/wb_slave_if.sv
      - source/wb_slave_decode.sv
      - source/setting_reg_bank.sv
      - source/boot_reset_ctrl.sv
      - source/readback_mux.sv
      - source/umtrx_ctrl_top.sv
  - target: test
    files:
      - tb/ctrl_checker.sv
      - tb/tb_umtrx_ctrl.sv
